// ==== hw/mac_core.sv ====
`timescale 1ns/1ps

module mac_core (
	input  logic                                        clk,
	input  logic                                        arst_n,
	input  logic                                        core_rst_n,
	input  mc_pkg::sample_t                             sample_in,
	input  logic [mc_pkg::TAPS*mc_pkg::WEIGHT_W-1:0]    weights,
	input  logic                                        grant,
	output logic                                        pending,
	output logic                                        ready,
	output logic signed [mc_pkg::RESULT_W-1:0]          value
);

	import mc_pkg::*;

	core_state_e                         state_q;
	logic        [TAP_W-1:0]             tap_q;
	logic signed [RESULT_W-1:0]          acc_q;
	logic signed [WEIGHT_W-1:0]          cur_w;
	logic signed [SAMPLE_W+WEIGHT_W-1:0] prod;
	logic                                take;

	// Weight for the current tap, read straight from the registers
	assign cur_w = $signed(weights[int'(tap_q)*WEIGHT_W +: WEIGHT_W]);
	assign prod  = sample_in.data * cur_w;

	assign take = (state_q == CORE_ACCUM) && sample_in.strobe;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= CORE_RESET;
			tap_q   <= '0;
			acc_q   <= '0;
		end else if (!core_rst_n) begin // Held by the sequencer
			state_q <= CORE_RESET;
			tap_q   <= '0;
			acc_q   <= '0;
		end else begin
			case (state_q)
				CORE_RESET: begin
					state_q <= CORE_ACCUM;
				end
				CORE_ACCUM: begin
					if (take) begin
						acc_q <= acc_q + RESULT_W'(prod);
						if (tap_q == TAP_W'(TAPS - 1)) begin
							tap_q   <= '0;
							state_q <= CORE_HOLD;
						end else begin
							tap_q <= tap_q + 1'b1;
						end
					end
				end
				CORE_HOLD: begin
					// Samples in this state are dropped
					if (grant) begin
						acc_q   <= '0;
						state_q <= CORE_ACCUM;
					end
				end
				default: begin
					state_q <= CORE_RESET;
				end
			endcase
		end
	end

	assign ready   = (state_q == CORE_ACCUM);
	assign pending = (state_q == CORE_HOLD);
	assign value   = acc_q;

	a_grant_pending: assert property (
		@(posedge clk) disable iff (!arst_n)
		grant |-> pending
	);

endmodule

// ==== hw/mc_pkg.sv ====
package mc_pkg;

	// Bank size
	localparam int NUM_CORES = 4;
	localparam int CORE_ID_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

	// Dot product length
	localparam int TAPS  = 4;
	localparam int TAP_W = (TAPS > 1) ? $clog2(TAPS) : 1;

	// Datapath widths
	localparam int SAMPLE_W = 19;
	localparam int WEIGHT_W = 7;
	localparam int RESULT_W = 28; // 26-bit products, sum of TAPS of them

	// Reset release spacing
	localparam int STAGGER_CYCLES = 25;
	localparam int STAGGER_W      = (STAGGER_CYCLES > 1) ? $clog2(STAGGER_CYCLES) : 1;

	// Broadcast input sample
	typedef struct packed {
		logic                       strobe;
		logic signed [SAMPLE_W-1:0] data;
	} sample_t;

	// Weight register write
	typedef struct packed {
		logic                       strobe;
		logic        [CORE_ID_W-1:0] core;
		logic        [TAP_W-1:0]     tap;
		logic signed [WEIGHT_W-1:0]  weight;
	} cfg_wr_t;

	// Arbitrated result
	typedef struct packed {
		logic                        strobe;
		logic        [CORE_ID_W-1:0] core;
		logic signed [RESULT_W-1:0]  value;
	} result_t;

	typedef enum logic [1:0] {
		CORE_RESET,
		CORE_ACCUM,
		CORE_HOLD
	} core_state_e;

	typedef enum logic {
		SEQ_STAGGER,
		SEQ_DONE
	} seq_state_e;

endpackage

// ==== hw/multicore.sv ====
`timescale 1ns/1ps

module multicore (
	input  logic                          clk,
	input  logic                          arst_n,
	input  mc_pkg::sample_t               sample_in,
	input  mc_pkg::cfg_wr_t               cfg_wr,
	output mc_pkg::result_t               result_out,
	output logic [mc_pkg::NUM_CORES-1:0]  cores_ready,
	output logic                          all_running
);

	import mc_pkg::*;

	logic [NUM_CORES-1:0]                 core_rst_n;
	logic [NUM_CORES*TAPS*WEIGHT_W-1:0]   weights;
	logic [NUM_CORES-1:0]                 pending;
	logic [NUM_CORES-1:0]                 grant;
	logic [NUM_CORES*RESULT_W-1:0]        values;

	reset_sequencer u_reset_sequencer (
		.clk         (clk),
		.arst_n      (arst_n),
		.core_rst_n  (core_rst_n),
		.all_running (all_running)
	);

	weight_regs u_weight_regs (
		.clk     (clk),
		.arst_n  (arst_n),
		.cfg_wr  (cfg_wr),
		.weights (weights)
	);

	// Every core sees the same sample stream
	for (genvar k = 0; k < NUM_CORES; k++) begin : g_core
		mac_core u_mac_core (
			.clk        (clk),
			.arst_n     (arst_n),
			.core_rst_n (core_rst_n[k]),
			.sample_in  (sample_in),
			.weights    (weights[k*TAPS*WEIGHT_W +: TAPS*WEIGHT_W]),
			.grant      (grant[k]),
			.pending    (pending[k]),
			.ready      (cores_ready[k]),
			.value      (values[k*RESULT_W +: RESULT_W])
		);
	end

	result_arbiter u_result_arbiter (
		.clk        (clk),
		.arst_n     (arst_n),
		.pending    (pending),
		.values     (values),
		.grant      (grant),
		.result_out (result_out)
	);

endmodule

// ==== hw/reset_sequencer.sv ====
`timescale 1ns/1ps

module reset_sequencer (
	input  logic                          clk,
	input  logic                          arst_n,
	output logic [mc_pkg::NUM_CORES-1:0]  core_rst_n,
	output logic                          all_running
);

	import mc_pkg::*;

	seq_state_e           state_q;
	logic [STAGGER_W-1:0] cnt_q;
	logic [CORE_ID_W-1:0] idx_q;  // Next core to release

	// Core 0 goes on the first edge, then one core every STAGGER_CYCLES
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q     <= SEQ_STAGGER;
			cnt_q       <= '0;
			idx_q       <= '0;
			core_rst_n  <= '0;
			all_running <= 1'b0;
		end else begin
			case (state_q)
				SEQ_STAGGER: begin
					if (cnt_q == '0) begin
						core_rst_n[idx_q] <= 1'b1;
						if (idx_q == CORE_ID_W'(NUM_CORES - 1)) begin
							state_q     <= SEQ_DONE;
							all_running <= 1'b1; // Same edge as the last release
						end else begin
							idx_q <= idx_q + 1'b1;
							cnt_q <= STAGGER_W'(STAGGER_CYCLES - 1);
						end
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				SEQ_DONE: begin
					state_q <= SEQ_DONE; // Only arst_n leaves this
				end
				default: begin
					state_q <= SEQ_STAGGER;
				end
			endcase
		end
	end

	// Once a core is running it stays running
	for (genvar k = 0; k < NUM_CORES; k++) begin : g_chk
		a_no_rerelease: assert property (
			@(posedge clk) disable iff (!arst_n)
			core_rst_n[k] |=> core_rst_n[k]
		);
	end

endmodule

// ==== hw/result_arbiter.sv ====
`timescale 1ns/1ps

module result_arbiter (
	input  logic                                           clk,
	input  logic                                           arst_n,
	input  logic [mc_pkg::NUM_CORES-1:0]                   pending,
	input  logic [mc_pkg::NUM_CORES*mc_pkg::RESULT_W-1:0]  values,
	output logic [mc_pkg::NUM_CORES-1:0]                   grant,
	output mc_pkg::result_t                                result_out
);

	import mc_pkg::*;

	logic        [CORE_ID_W-1:0] grant_idx;
	logic                        strobe_q;
	logic        [CORE_ID_W-1:0] core_q;
	logic signed [RESULT_W-1:0]  value_q;

	// Lowest pending index wins, scanned from the top down
	always_comb begin
		grant     = '0;
		grant_idx = '0;
		for (int k = NUM_CORES - 1; k >= 0; k--) begin
			if (pending[k]) begin
				grant     = '0;
				grant[k]  = 1'b1;
				grant_idx = CORE_ID_W'(k);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= |grant; // One cycle per grant
		end
	end

	always_ff @(posedge clk) begin
		if (|grant) begin
			core_q  <= grant_idx;
			value_q <= $signed(values[int'(grant_idx)*RESULT_W +: RESULT_W]);
		end
	end

	assign result_out = '{strobe: strobe_q, core: core_q, value: value_q};

	a_grant_onehot: assert property (
		@(posedge clk) disable iff (!arst_n)
		$onehot0(grant)
	);

endmodule

// ==== hw/weight_regs.sv ====
`timescale 1ns/1ps

module weight_regs (
	input  logic                                                     clk,
	input  logic                                                     arst_n,
	input  mc_pkg::cfg_wr_t                                          cfg_wr,
	output logic [mc_pkg::NUM_CORES*mc_pkg::TAPS*mc_pkg::WEIGHT_W-1:0] weights
);

	import mc_pkg::*;

	logic signed [WEIGHT_W-1:0] w_q [NUM_CORES][TAPS];
	logic                       wr_ok;

	// Out of range writes are dropped
	assign wr_ok = cfg_wr.strobe && (int'(cfg_wr.core) < NUM_CORES) &&
		(int'(cfg_wr.tap) < TAPS);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int c = 0; c < NUM_CORES; c++) begin
				for (int t = 0; t < TAPS; t++) begin
					w_q[c][t] <= WEIGHT_W'(1); // Unity weights
				end
			end
		end else if (wr_ok) begin
			w_q[cfg_wr.core][cfg_wr.tap] <= cfg_wr.weight;
		end
	end

	// Flatten, core major then tap
	always_comb begin
		weights = '0;
		for (int c = 0; c < NUM_CORES; c++) begin
			for (int t = 0; t < TAPS; t++) begin
				weights[(c*TAPS + t)*WEIGHT_W +: WEIGHT_W] = w_q[c][t];
			end
		end
	end

	a_core_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		cfg_wr.strobe |-> (int'(cfg_wr.core) < NUM_CORES)
	);

endmodule

// ==== project.f ====
hw/mc_pkg.sv
hw/reset_sequencer.sv
hw/weight_regs.sv
hw/mac_core.sv
hw/result_arbiter.sv
hw/multicore.sv
tests/tb_multicore.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_multicore -f project.f \
	&& ./obj_dir/Vtb_multicore | tee sim.log \
	&& grep -q "^NO ERRORS$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== tests/tb_multicore.sv ====
`timescale 1ns/1ps

module tb_multicore;

	import mc_pkg::*;

	localparam int DRIVE_DLY   = 2;
	localparam int WAIT_LIMIT  = 200;
	localparam int RESET_LIMIT = NUM_CORES*STAGGER_CYCLES + 50;
	localparam int EXP_DEPTH   = 64;
	localparam int READY_EDGES = 2; // Release edge, then the edge out of CORE_RESET
	localparam int ALL_EDGES   = (NUM_CORES - 1)*STAGGER_CYCLES + 1; // With the last release

	localparam logic signed [SAMPLE_W-1:0] S_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};
	localparam logic signed [SAMPLE_W-1:0] S_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
	localparam logic signed [WEIGHT_W-1:0] W_MIN = {1'b1, {(WEIGHT_W-1){1'b0}}};
	localparam logic signed [WEIGHT_W-1:0] W_MAX = {1'b0, {(WEIGHT_W-1){1'b1}}};

	logic                 clk;
	logic                 arst_n;
	sample_t              sample_in;
	cfg_wr_t              cfg_wr;
	result_t              result_out;
	logic [NUM_CORES-1:0] cores_ready;
	logic                 all_running;

	int seed;
	int errors;
	int tests_run;
	int tests_failed;
	bit hung;

	int                   edge_cnt; // Edges since the release of arst_n
	logic [NUM_CORES-1:0] ready_seen;
	logic                 running_seen;

	// Reference model state
	logic signed [WEIGHT_W-1:0] w_model [NUM_CORES][TAPS];
	logic signed [SAMPLE_W-1:0] blk [TAPS];

	// Expected results in arrival order
	logic        [CORE_ID_W-1:0] exp_core [EXP_DEPTH];
	logic signed [RESULT_W-1:0]  exp_val  [EXP_DEPTH];
	logic                        exp_adj  [EXP_DEPTH]; // Next result must follow at once
	int                          rd_ptr;
	int                          wr_ptr;

	multicore u_multicore (
		.clk         (clk),
		.arst_n      (arst_n),
		.sample_in   (sample_in),
		.cfg_wr      (cfg_wr),
		.result_out  (result_out),
		.cores_ready (cores_ready),
		.all_running (all_running)
	);

	always #10 clk = ~clk;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			edge_cnt     <= 0;
			ready_seen   <= '0;
			running_seen <= 1'b0;
			rd_ptr       <= 0;
		end else begin
			edge_cnt     <= edge_cnt + 1;
			ready_seen   <= ready_seen | cores_ready;
			running_seen <= running_seen | all_running;
			if (result_out.strobe) begin
				rd_ptr <= rd_ptr + 1;
			end
		end
	end

	a_reset_strobe: assert property (@(posedge clk) !arst_n |-> !result_out.strobe)
		else begin
			errors++;
			$display("CHECK FAILED result_out.strobe = 0x%h in reset, expected 0x0",
				$sampled(result_out.strobe));
		end

	a_reset_ready: assert property (@(posedge clk) !arst_n |-> (cores_ready == '0))
		else begin
			errors++;
			$display("CHECK FAILED cores_ready = 0x%h in reset, expected 0x0",
				$sampled(cores_ready));
		end

	// First rise of each ready bit, STAGGER_CYCLES apart
	for (genvar k = 0; k < NUM_CORES; k++) begin : g_release
		a_ready_edge: assert property (@(posedge clk) disable iff (!arst_n)
			(cores_ready[k] && !ready_seen[k]) |-> (edge_cnt == k*STAGGER_CYCLES + READY_EDGES))
			else begin
				errors++;
				$display("CHECK FAILED cores_ready[%0d] rise edge = 0x%h, expected 0x%h",
					k, $sampled(edge_cnt), k*STAGGER_CYCLES + READY_EDGES);
			end
	end

	a_running_edge: assert property (@(posedge clk) disable iff (!arst_n)
		(all_running && !running_seen) |-> (edge_cnt == ALL_EDGES))
		else begin
			errors++;
			$display("CHECK FAILED all_running rise edge = 0x%h, expected 0x%h",
				$sampled(edge_cnt), ALL_EDGES);
		end

	a_running_stays: assert property (@(posedge clk) disable iff (!arst_n)
		running_seen |-> all_running)
		else begin
			errors++;
			$display("CHECK FAILED all_running = 0x0 after release, expected 0x1");
		end

	a_result_expected: assert property (@(posedge clk) disable iff (!arst_n)
		result_out.strobe |-> (rd_ptr < wr_ptr))
		else begin
			errors++;
			$display("A result from core %0d arrived when none was expected",
				$sampled(result_out.core));
		end

	a_result_core: assert property (@(posedge clk) disable iff (!arst_n)
		(result_out.strobe && rd_ptr < wr_ptr) |-> (result_out.core == exp_core[rd_ptr]))
		else begin
			errors++;
			$display("CHECK FAILED result_out.core = 0x%h, expected 0x%h",
				$sampled(result_out.core), exp_core[$sampled(rd_ptr)]);
		end

	a_result_value: assert property (@(posedge clk) disable iff (!arst_n)
		(result_out.strobe && rd_ptr < wr_ptr) |-> (result_out.value == exp_val[rd_ptr]))
		else begin
			errors++;
			$display("CHECK FAILED result_out.value = 0x%h, expected 0x%h (core %0d)",
				$sampled(result_out.value), exp_val[$sampled(rd_ptr)],
				$sampled(result_out.core));
		end

	a_result_burst: assert property (@(posedge clk) disable iff (!arst_n)
		(result_out.strobe && rd_ptr < wr_ptr && exp_adj[rd_ptr]) |=> result_out.strobe)
		else begin
			errors++;
			$display("CHECK FAILED result_out.strobe = 0x0 inside a burst, expected 0x1");
		end

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic write_weight(input int c, input int t, input logic signed [WEIGHT_W-1:0] w);
		next_cycle();
		cfg_wr.strobe = 1'b1;
		cfg_wr.core   = CORE_ID_W'(c);
		cfg_wr.tap    = TAP_W'(t);
		cfg_wr.weight = w;
		w_model[c][t] = w;
	endtask

	task automatic close_writes();
		next_cycle();
		cfg_wr = '0;
	endtask

	task automatic send_sample(input logic signed [SAMPLE_W-1:0] d);
		next_cycle();
		sample_in.strobe = 1'b1;
		sample_in.data   = d;
	endtask

	task automatic idle_input();
		next_cycle();
		sample_in = '0;
	endtask

	task automatic send_block();
		for (int t = 0; t < TAPS; t++) begin
			send_sample(blk[t]);
		end
		idle_input();
	endtask

	task automatic random_block();
		for (int t = 0; t < TAPS; t++) begin
			blk[t] = SAMPLE_W'($random(seed));
		end
	endtask

	task automatic push_expect(input int c, input logic signed [RESULT_W-1:0] v, input logic adj);
		if (wr_ptr < EXP_DEPTH) begin
			exp_core[wr_ptr] = CORE_ID_W'(c);
			exp_val[wr_ptr]  = v;
			exp_adj[wr_ptr]  = adj;
			wr_ptr++;
		end else begin
			errors++;
			$display("The expected-result queue is full");
		end
	endtask

	function automatic logic signed [RESULT_W-1:0] expected_dot(input int c);
		longint sum;
		sum = 0;
		for (int t = 0; t < TAPS; t++) begin
			sum += longint'(blk[t]) * longint'(w_model[c][t]);
		end
		return RESULT_W'(sum);
	endfunction

	task automatic push_round();
		for (int c = 0; c < NUM_CORES; c++) begin
			push_expect(c, expected_dot(c), c != NUM_CORES - 1);
		end
	endtask

	task automatic wait_all_ready();
		int n;
		n = 0;
		while (!(&cores_ready) && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!(&cores_ready)) begin
			$display("Timeout: the cores did not all return to accumulating");
			hung = 1'b1;
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (rd_ptr != wr_ptr && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (rd_ptr != wr_ptr) begin
			$display("Timeout: %0d expected results never arrived", wr_ptr - rd_ptr);
			hung = 1'b1;
		end
		next_cycle(); // Lets the burst check see the cycle after the last result
		next_cycle();
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (hung || errors != errs_before) begin
			tests_failed++;
			$display("%s: failed", name);
		end else begin
			$display("%s: passed", name);
		end
	endtask

	task automatic test_reset_outputs();
		int e0;
		e0 = errors;
		repeat (10) @(posedge clk);
		#DRIVE_DLY;
		arst_n = 1'b1;
		finish_test("outputs in reset", e0);
	endtask

	task automatic test_release();
		int e0;
		int n;
		e0 = errors;
		n  = 0;
		while (!(all_running && &cores_ready) && n < RESET_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!(all_running && &cores_ready)) begin
			$display("Timeout: the cores were never all released");
			hung = 1'b1;
		end
		finish_test("staggered release", e0);
	endtask

	task automatic test_default_weights();
		int     e0;
		longint sum;
		e0 = errors;
		wait_all_ready();
		if (!hung) begin
			random_block();
			sum = 0;
			for (int t = 0; t < TAPS; t++) begin
				sum += longint'(blk[t]); // Unity weights give the plain sum
			end
			for (int c = 0; c < NUM_CORES; c++) begin
				push_expect(c, RESULT_W'(sum), c != NUM_CORES - 1);
			end
			send_block();
			wait_drain();
		end
		finish_test("default weights", e0);
	endtask

	task automatic test_programmed_weights();
		int e0;
		e0 = errors;
		for (int c = 0; c < NUM_CORES; c++) begin
			for (int t = 0; t < TAPS; t++) begin
				write_weight(c, t, WEIGHT_W'($random(seed)));
			end
		end
		close_writes();
		wait_all_ready();
		if (!hung) begin
			random_block();
			push_round();
			send_block();
			wait_drain();
		end
		finish_test("programmed weights", e0);
	endtask

	task automatic test_held_drop();
		int                         e0;
		logic signed [SAMPLE_W-1:0] extra;
		longint                     sum0;
		e0 = errors;
		wait_all_ready();
		if (!hung) begin
			random_block();
			push_round();
			send_block(); // Its idle cycle is the one where core 0 is granted
			extra = SAMPLE_W'($random(seed));
			send_sample(extra); // Core 0 accumulates again, core 1 is being granted
			idle_input();
			wait_drain();
			wait_all_ready();
		end
		if (!hung) begin
			random_block();
			// Core 0 starts at tap 1 and drops the last sample while it holds
			sum0 = longint'(extra) * longint'(w_model[0][0]);
			for (int t = 1; t < TAPS; t++) begin
				sum0 += longint'(blk[t-1]) * longint'(w_model[0][t]);
			end
			push_expect(0, RESULT_W'(sum0), 1'b1);
			for (int c = 1; c < NUM_CORES; c++) begin
				push_expect(c, expected_dot(c), c != NUM_CORES - 1);
			end
			send_block();
			wait_drain();
		end
		finish_test("held results drop samples", e0);
	endtask

	task automatic test_extreme_values();
		int                         e0;
		logic signed [WEIGHT_W-1:0] w;
		e0 = errors;
		for (int c = 0; c < NUM_CORES; c++) begin
			for (int t = 0; t < TAPS; t++) begin
				case (c % 4)
					0: w = (t < TAPS/2) ? W_MIN : W_MAX; // Largest positive sum
					1: w = (t < TAPS/2) ? W_MAX : W_MIN; // Largest negative sum
					2: w = W_MIN;
					default: w = W_MAX;
				endcase
				write_weight(c, t, w);
			end
		end
		close_writes();
		wait_all_ready();
		if (!hung) begin
			for (int t = 0; t < TAPS; t++) begin
				blk[t] = (t < TAPS/2) ? S_MIN : S_MAX;
			end
			push_round();
			send_block();
			wait_drain();
		end
		finish_test("extreme values", e0);
	endtask

	initial begin
		seed         = 32'h8588_8a79;
		clk          = 1'b0;
		arst_n       = 1'b0;
		sample_in    = '0;
		cfg_wr       = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		hung         = 1'b0;
		wr_ptr       = 0;
		for (int c = 0; c < NUM_CORES; c++) begin
			for (int t = 0; t < TAPS; t++) begin
				w_model[c][t] = WEIGHT_W'(1); // Matches the register reset
			end
		end

		test_reset_outputs();
		if (!hung) test_release();
		if (!hung) test_default_weights();
		if (!hung) test_programmed_weights();
		if (!hung) test_held_drop();
		if (!hung) test_extreme_values();

		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && !hung) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
